// ==== uart_pkg.sv ====
package uart_pkg;

  localparam int bit_time = 16; // clocks per serial bit.
  localparam int bit_cnt_w = $clog2(bit_time);
  localparam int word_bytes = 2;
  localparam int byte_idx_w = (word_bytes > 1) ? $clog2(word_bytes) : 1;
  localparam int fifo_depth_w = 3; // 8 entries per fifo.

  typedef logic [7:0] byte_t;
  typedef logic [8*word_bytes-1:0] word_t;
  typedef logic [7:0] addr_t;
  typedef logic [bit_cnt_w-1:0] bit_cnt_t;
  typedef logic [byte_idx_w-1:0] byte_idx_t;

  localparam addr_t addr_data = 8'h00;
  localparam addr_t addr_status = 8'h04;

  // status register bits.
  localparam int st_rx_avail = 0;
  localparam int st_tx_space = 1;
  localparam int st_tx_idle = 2;
  localparam int st_overrun = 3;

  typedef struct packed {
    addr_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    word_t pwdata;
  } apb_req_t;

  typedef struct packed {
    word_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    rx_idle, rx_start, rx_data, rx_stop
  } rx_state_t;

  typedef enum logic [1:0] {
    tx_idle, tx_start, tx_data, tx_stop
  } tx_state_t;

endpackage

// ==== byte_fifo.sv ====
`timescale 1ns/10ps

module byte_fifo #(
  parameter int depth_w = 3,
  parameter int width = 8
) (
  input  logic             clk,
  input  logic             anrst,
  input  logic [width-1:0] in_data,
  input  logic             in_valid,
  output logic             in_ready,
  output logic [width-1:0] out_data,
  output logic             out_valid,
  input  logic             out_ready
);

  logic [width-1:0] mem [2**depth_w];
  logic [depth_w:0] wptr; // msb is the wrap bit.
  logic [depth_w:0] rptr;
  logic [depth_w:0] level;
  logic             push;
  logic             pop;

  assign level = wptr - rptr;
  assign out_valid = wptr != rptr;
  assign out_data = mem[rptr[depth_w-1:0]];
  assign in_ready = !level[depth_w] || out_ready; // full only frees on a pop.
  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (push) wptr <= wptr + 1'b1;
      if (pop) rptr <= rptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wptr[depth_w-1:0]] <= in_data;
  end

  a_level: assert property (@(posedge clk) disable iff (!anrst)
    level <= (1 << depth_w));

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx (
  input  logic            clk,
  input  logic            anrst,
  input  logic            rx,
  output uart_pkg::byte_t rx_byte,
  output logic            rx_byte_valid
);

  logic                rx_meta;
  logic                rx_sync;
  uart_pkg::rx_state_t state;
  uart_pkg::bit_cnt_t  cnt;
  logic [2:0]          bit_idx;
  uart_pkg::byte_t     shift;
  logic                bit_end;
  logic                half_end;

  assign bit_end = cnt == uart_pkg::bit_cnt_t'(uart_pkg::bit_time - 1);
  assign half_end = cnt == uart_pkg::bit_cnt_t'(uart_pkg::bit_time / 2 - 1);
  assign rx_byte = shift;

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      rx_meta <= 1'b1; // line idles high.
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      state <= uart_pkg::rx_idle;
      cnt <= '0;
      bit_idx <= '0;
      rx_byte_valid <= 1'b0;
    end else begin
      rx_byte_valid <= 1'b0;
      cnt <= cnt + 1'b1;
      case (state)
        uart_pkg::rx_idle: begin
          cnt <= '0;
          if (!rx_sync) state <= uart_pkg::rx_start;
        end
        uart_pkg::rx_start: begin
          if (half_end) begin
            cnt <= '0;
            bit_idx <= '0;
            state <= rx_sync ? uart_pkg::rx_idle : uart_pkg::rx_data; // glitch check.
          end
        end
        uart_pkg::rx_data: begin
          if (bit_end) begin
            cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= uart_pkg::rx_stop;
          end
        end
        uart_pkg::rx_stop: begin
          if (bit_end) begin
            rx_byte_valid <= rx_sync; // bad stop bit drops the frame.
            state <= uart_pkg::rx_idle;
          end
        end
        default: state <= uart_pkg::rx_idle;
      endcase
    end
  end

  // lsb arrives first.
  always_ff @(posedge clk) begin
    if (state == uart_pkg::rx_data && bit_end) shift <= {rx_sync, shift[7:1]};
  end

  a_valid_pulse: assert property (@(posedge clk) disable iff (!anrst)
    rx_byte_valid |=> !rx_byte_valid);

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx (
  input  logic            clk,
  input  logic            anrst,
  input  uart_pkg::byte_t data,
  input  logic            valid,
  output logic            ready,
  output logic            tx
);

  uart_pkg::tx_state_t state;
  uart_pkg::bit_cnt_t  cnt;
  logic [2:0]          bit_idx;
  uart_pkg::byte_t     shift;
  logic                bit_end;

  assign bit_end = cnt == uart_pkg::bit_cnt_t'(uart_pkg::bit_time - 1);
  assign ready = state == uart_pkg::tx_idle;

  always_comb begin
    case (state)
      uart_pkg::tx_start: tx = 1'b0;
      uart_pkg::tx_data:  tx = shift[0];
      default:            tx = 1'b1; // idle and stop.
    endcase
  end

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      state <= uart_pkg::tx_idle;
      cnt <= '0;
      bit_idx <= '0;
    end else begin
      cnt <= cnt + 1'b1;
      case (state)
        uart_pkg::tx_idle: begin
          cnt <= '0;
          if (valid) state <= uart_pkg::tx_start;
        end
        uart_pkg::tx_start: begin
          if (bit_end) begin
            cnt <= '0;
            bit_idx <= '0;
            state <= uart_pkg::tx_data;
          end
        end
        uart_pkg::tx_data: begin
          if (bit_end) begin
            cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) state <= uart_pkg::tx_stop;
          end
        end
        uart_pkg::tx_stop: begin
          if (bit_end) state <= uart_pkg::tx_idle;
        end
        default: state <= uart_pkg::tx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ready && valid) begin
      shift <= data;
    end else if (state == uart_pkg::tx_data && bit_end) begin
      shift <= shift >> 1;
    end
  end

  a_data_hold: assert property (@(posedge clk) disable iff (!anrst)
    valid && !ready |=> valid && $stable(data));

endmodule

// ==== uart_apb_port.sv ====
`timescale 1ns/10ps

module uart_apb_port (
  input  logic               clk,
  input  logic               anrst,
  input  uart_pkg::apb_req_t apb,
  output uart_pkg::apb_rsp_t apb_rsp,
  output uart_pkg::word_t    tx_push_data,
  output logic               tx_push_valid,
  input  logic               tx_push_ready,
  input  uart_pkg::word_t    tx_head,
  input  logic               tx_head_valid,
  output logic               tx_pop,
  output uart_pkg::byte_t    tx_byte,
  output logic               tx_byte_valid,
  input  logic               tx_byte_ready,
  input  logic               tx_busy,
  input  uart_pkg::byte_t    rx_byte,
  input  logic               rx_byte_valid,
  output uart_pkg::word_t    rx_push_data,
  output logic               rx_push_valid,
  input  logic               rx_push_ready,
  input  uart_pkg::word_t    rx_head,
  input  logic               rx_head_valid,
  output logic               rx_pop
);

  logic                access;
  logic                is_data;
  logic                is_status;
  logic                wr_data;
  logic                rd_data;
  logic                rd_status;
  uart_pkg::byte_idx_t tx_idx;
  uart_pkg::byte_idx_t rx_idx;
  logic                tx_last;
  logic                rx_last;
  uart_pkg::word_t     rx_pack;
  uart_pkg::word_t     status;
  logic                overrun;

  assign access = apb.psel && apb.penable;
  assign is_data = apb.paddr == uart_pkg::addr_data;
  assign is_status = apb.paddr == uart_pkg::addr_status;
  assign wr_data = access && is_data && apb.pwrite;
  assign rd_data = access && is_data && !apb.pwrite;
  assign rd_status = access && is_status && !apb.pwrite; // never waits.

  always_comb begin
    status = '0;
    status[uart_pkg::st_rx_avail] = rx_head_valid;
    status[uart_pkg::st_tx_space] = tx_push_ready;
    status[uart_pkg::st_tx_idle] = !tx_head_valid && !tx_busy;
    status[uart_pkg::st_overrun] = overrun;
  end

  always_comb begin
    apb_rsp = '0;
    if (access) begin
      if (is_data) begin
        apb_rsp.pready = apb.pwrite ? tx_push_ready : rx_head_valid; // wait on fifo.
        if (!apb.pwrite) apb_rsp.prdata = rx_head;
      end else if (is_status) begin
        apb_rsp.pready = 1'b1;
        if (!apb.pwrite) apb_rsp.prdata = status;
      end else begin
        apb_rsp.pready = 1'b1;
        apb_rsp.pslverr = 1'b1; // unmapped.
      end
    end
  end

  assign tx_push_data = apb.pwdata;
  assign tx_push_valid = wr_data;
  assign rx_pop = rd_data && rx_head_valid;

  // unpack the head word, low byte first.
  assign tx_last = tx_idx == uart_pkg::byte_idx_t'(uart_pkg::word_bytes - 1);
  assign tx_byte = tx_head[tx_idx*8 +: 8];
  assign tx_byte_valid = tx_head_valid;
  assign tx_pop = tx_byte_valid && tx_byte_ready && tx_last;

  assign rx_last = rx_idx == uart_pkg::byte_idx_t'(uart_pkg::word_bytes - 1);
  assign rx_push_data = rx_pack;

  always_ff @(posedge clk, negedge anrst) begin
    if (!anrst) begin
      tx_idx <= '0;
      rx_idx <= '0;
      rx_push_valid <= 1'b0;
      overrun <= 1'b0;
    end else begin
      if (tx_byte_valid && tx_byte_ready) tx_idx <= tx_last ? '0 : tx_idx + 1'b1;
      if (rx_byte_valid) rx_idx <= rx_last ? '0 : rx_idx + 1'b1;
      rx_push_valid <= rx_byte_valid && rx_last; // push one cycle later.
      if (rx_push_valid && !rx_push_ready) begin
        overrun <= 1'b1; // word lost.
      end else if (rd_status) begin
        overrun <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_byte_valid) rx_pack[rx_idx*8 +: 8] <= rx_byte;
  end

  a_req_hold: assert property (@(posedge clk) disable iff (!anrst)
    access && !apb_rsp.pready |=> $stable(apb));

endmodule

// ==== uart_top.sv ====
`timescale 1ns/10ps

module uart_top (
  input  logic               clk,
  input  logic               anrst,
  input  uart_pkg::apb_req_t apb,
  output uart_pkg::apb_rsp_t apb_rsp,
  input  logic               rx,
  output logic               tx
);

  uart_pkg::word_t tx_push_data;
  logic            tx_push_valid;
  logic            tx_push_ready;
  uart_pkg::word_t tx_head;
  logic            tx_head_valid;
  logic            tx_pop;
  uart_pkg::byte_t tx_byte;
  logic            tx_byte_valid;
  logic            tx_byte_ready;
  logic            tx_busy;
  uart_pkg::byte_t rx_byte;
  logic            rx_byte_valid;
  uart_pkg::word_t rx_push_data;
  logic            rx_push_valid;
  logic            rx_push_ready;
  uart_pkg::word_t rx_head;
  logic            rx_head_valid;
  logic            rx_pop;

  assign tx_busy = !tx_byte_ready; // transmitter mid frame.

  uart_apb_port i_uart_apb_port (
    .clk           (clk),
    .anrst         (anrst),
    .apb           (apb),
    .apb_rsp       (apb_rsp),
    .tx_push_data  (tx_push_data),
    .tx_push_valid (tx_push_valid),
    .tx_push_ready (tx_push_ready),
    .tx_head       (tx_head),
    .tx_head_valid (tx_head_valid),
    .tx_pop        (tx_pop),
    .tx_byte       (tx_byte),
    .tx_byte_valid (tx_byte_valid),
    .tx_byte_ready (tx_byte_ready),
    .tx_busy       (tx_busy),
    .rx_byte       (rx_byte),
    .rx_byte_valid (rx_byte_valid),
    .rx_push_data  (rx_push_data),
    .rx_push_valid (rx_push_valid),
    .rx_push_ready (rx_push_ready),
    .rx_head       (rx_head),
    .rx_head_valid (rx_head_valid),
    .rx_pop        (rx_pop)
  );

  byte_fifo #(
    .depth_w (uart_pkg::fifo_depth_w),
    .width   ($bits(uart_pkg::word_t))
  ) i_tx_fifo (
    .clk       (clk),
    .anrst     (anrst),
    .in_data   (tx_push_data),
    .in_valid  (tx_push_valid),
    .in_ready  (tx_push_ready),
    .out_data  (tx_head),
    .out_valid (tx_head_valid),
    .out_ready (tx_pop)
  );

  byte_fifo #(
    .depth_w (uart_pkg::fifo_depth_w),
    .width   ($bits(uart_pkg::word_t))
  ) i_rx_fifo (
    .clk       (clk),
    .anrst     (anrst),
    .in_data   (rx_push_data),
    .in_valid  (rx_push_valid),
    .in_ready  (rx_push_ready),
    .out_data  (rx_head),
    .out_valid (rx_head_valid),
    .out_ready (rx_pop)
  );

  uart_tx i_uart_tx (
    .clk   (clk),
    .anrst (anrst),
    .data  (tx_byte),
    .valid (tx_byte_valid),
    .ready (tx_byte_ready),
    .tx    (tx)
  );

  uart_rx i_uart_rx (
    .clk           (clk),
    .anrst         (anrst),
    .rx            (rx),
    .rx_byte       (rx_byte),
    .rx_byte_valid (rx_byte_valid)
  );

endmodule

// ==== tb_uart_top.sv ====
`timescale 1ns/10ps

module tb_uart_top;

  localparam int frame_cycles = 10 * uart_pkg::bit_time;
  localparam int timeout_cycles = 50 * frame_cycles * 5; // 50 frames in all with a wide margin.
  localparam uart_pkg::addr_t addr_unmapped = 8'h08;

  logic               clk;
  logic               anrst;
  logic               rx;
  logic               tx;
  uart_pkg::apb_req_t apb;
  uart_pkg::apb_rsp_t apb_rsp;
  uart_pkg::byte_t    tx_q[$];
  logic [15:0]        lfsr = 16'd29;
  int                 cycle = 0;
  int                 checks = 0;
  int                 errors = 0;

  uart_top i_uart_top (
    .clk     (clk),
    .anrst   (anrst),
    .apb     (apb),
    .apb_rsp (apb_rsp),
    .rx      (rx),
    .tx      (tx)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = !clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s at %0t: expected 0x%0h, got 0x%0h", name, $time, exp, got);
    end
  endtask

  // fibonacci lfsr with taps 16 14 13 11.
  function automatic uart_pkg::word_t rand_bits(input int n);
    uart_pkg::word_t v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v = {v[14:0], fb};
    end
    return v;
  endfunction

  function automatic uart_pkg::word_t status_word(input logic rx_avail, input logic tx_space,
                                                  input logic tx_idle, input logic overrun);
    uart_pkg::word_t w;
    w = '0;
    w[uart_pkg::st_rx_avail] = rx_avail;
    w[uart_pkg::st_tx_space] = tx_space;
    w[uart_pkg::st_tx_idle] = tx_idle;
    w[uart_pkg::st_overrun] = overrun;
    return w;
  endfunction

  task automatic apb_transfer(input uart_pkg::addr_t addr, input logic write,
                             input uart_pkg::word_t wdata, output uart_pkg::word_t rdata,
                             output logic err, output int waits);
    uart_pkg::apb_req_t req;
    req = '0;
    req.paddr = addr;
    req.psel = 1'b1;
    req.pwrite = write;
    req.pwdata = wdata;
    waits = 0;
    @(posedge clk);
    apb <= req; // setup phase.
    req.penable = 1'b1;
    @(posedge clk);
    apb <= req;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      waits++;
      @(negedge clk);
    end
    rdata = apb_rsp.prdata;
    err = apb_rsp.pslverr;
    @(posedge clk);
    apb <= '0; // transfer completes on this edge.
  endtask

  task automatic apb_write(input uart_pkg::addr_t addr, input uart_pkg::word_t wdata,
                          output logic err, output int waits);
    uart_pkg::word_t unused_rdata;
    apb_transfer(addr, 1'b1, wdata, unused_rdata, err, waits);
  endtask

  task automatic apb_read(input uart_pkg::addr_t addr, output uart_pkg::word_t rdata,
                         output logic err, output int waits);
    apb_transfer(addr, 1'b0, '0, rdata, err, waits);
  endtask

  task automatic send_byte(input uart_pkg::byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0}; // stop, data lsb first, start.
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= frame[i];
      repeat (uart_pkg::bit_time - 1) @(posedge clk);
    end
  endtask

  task automatic watch_tx();
    uart_pkg::byte_t b;
    forever begin
      @(negedge clk);
      if (anrst && !tx) begin
        repeat (uart_pkg::bit_time / 2) @(negedge clk); // middle of the start bit.
        check("tx start bit", 0, tx);
        for (int i = 0; i < 8; i++) begin
          repeat (uart_pkg::bit_time) @(negedge clk);
          b[i] = tx;
        end
        repeat (uart_pkg::bit_time) @(negedge clk);
        check("tx stop bit", 1, tx);
        tx_q.push_back(b);
      end
    end
  endtask

  task automatic reset_state();
    uart_pkg::word_t data;
    logic err;
    int waits;
    @(negedge clk);
    check("tx", 1, tx);
    apb_read(uart_pkg::addr_status, data, err, waits);
    check("status", status_word(0, 1, 1, 0), data);
    check("status wait states", 0, waits);
    check("pslverr", 0, err);
  endtask

  task automatic transmit_word();
    uart_pkg::word_t word;
    uart_pkg::word_t data;
    logic err;
    int waits;
    word = rand_bits(16);
    tx_q.delete();
    apb_write(uart_pkg::addr_data, word, err, waits);
    check("pslverr", 0, err);
    while (tx_q.size() < 2) @(posedge clk);
    check("tx byte 0", word[7:0], tx_q[0]);
    check("tx byte 1", word[15:8], tx_q[1]);
    repeat (uart_pkg::bit_time) @(posedge clk); // rest of the stop bit.
    apb_read(uart_pkg::addr_status, data, err, waits);
    check("status", status_word(0, 1, 1, 0), data);
  endtask

  task automatic receive_packed();
    uart_pkg::byte_t b0;
    uart_pkg::byte_t b1;
    uart_pkg::word_t data;
    logic err;
    int waits;
    int second_cycle;
    int done_cycle;
    b0 = uart_pkg::byte_t'(rand_bits(8));
    b1 = uart_pkg::byte_t'(rand_bits(8));
    send_byte(b0);
    send_byte(b1);
    apb_read(uart_pkg::addr_status, data, err, waits);
    check("status", status_word(1, 1, 1, 0), data);
    apb_read(uart_pkg::addr_data, data, err, waits);
    check("rx data", {b1, b0}, data);
    // read waits on an empty fifo.
    b0 = uart_pkg::byte_t'(rand_bits(8));
    b1 = uart_pkg::byte_t'(rand_bits(8));
    fork
      begin
        apb_read(uart_pkg::addr_data, data, err, waits);
        done_cycle = cycle;
      end
      begin
        send_byte(b0);
        second_cycle = cycle;
        send_byte(b1);
      end
    join
    check("rx data", {b1, b0}, data);
    check("read done after second byte", 1,
          done_cycle > second_cycle + 9 * uart_pkg::bit_time);
  endtask

  task automatic tx_backpressure();
    uart_pkg::word_t words[12];
    uart_pkg::word_t data;
    logic err;
    int waits;
    tx_q.delete();
    for (int i = 0; i < 12; i++) begin
      words[i] = rand_bits(16);
      apb_write(uart_pkg::addr_data, words[i], err, waits);
      check($sformatf("write %0d stalled", i), i >= 8, waits > 0); // fifo holds 8.
    end
    apb_read(uart_pkg::addr_status, data, err, waits);
    check("status", status_word(0, 0, 0, 0), data); // fifo full and sending.
    while (tx_q.size() < 24) @(posedge clk);
    for (int i = 0; i < 24; i++) begin
      check($sformatf("tx byte %0d", i), words[i / 2][(i % 2) * 8 +: 8], tx_q[i]);
    end
  endtask

  task automatic rx_overrun();
    uart_pkg::word_t words[9];
    uart_pkg::word_t data;
    logic err;
    int waits;
    for (int i = 0; i < 9; i++) begin
      words[i] = rand_bits(16);
      send_byte(words[i][7:0]);
      send_byte(words[i][15:8]);
    end
    apb_read(uart_pkg::addr_status, data, err, waits);
    check("status", status_word(1, 1, 1, 1), data);
    apb_read(uart_pkg::addr_status, data, err, waits);
    check("status", status_word(1, 1, 1, 0), data);
    for (int i = 0; i < 8; i++) begin
      apb_read(uart_pkg::addr_data, data, err, waits);
      check($sformatf("rx word %0d", i), words[i], data);
    end
    apb_read(uart_pkg::addr_status, data, err, waits);
    check("status", status_word(0, 1, 1, 0), data);
  endtask

  task automatic unmapped_access();
    uart_pkg::word_t word;
    uart_pkg::word_t data;
    logic err;
    int waits;
    word = rand_bits(16);
    send_byte(word[7:0]);
    send_byte(word[15:8]);
    apb_write(addr_unmapped, rand_bits(16), err, waits);
    check("pslverr on write", 1, err);
    check("write wait states", 0, waits);
    apb_read(addr_unmapped, data, err, waits);
    check("pslverr on read", 1, err);
    apb_read(uart_pkg::addr_status, data, err, waits);
    check("status", status_word(1, 1, 1, 0), data); // tx fifo still empty.
    apb_read(uart_pkg::addr_data, data, err, waits);
    check("rx data", word, data);
  endtask

  initial begin
    anrst = 1'b0;
    rx = 1'b1;
    apb = '0;
    fork
      watch_tx();
    join_none
    repeat (10) @(posedge clk);
    anrst <= 1'b1;
    reset_state();
    transmit_word();
    receive_packed();
    tx_backpressure();
    rx_overrun();
    unmapped_access();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    wait (cycle >= timeout_cycles);
    errors++;
    $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
uart_pkg.sv
byte_fifo.sv
uart_rx.sv
uart_tx.sv
uart_apb_port.sv
uart_top.sv
tb_uart_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only -Wall --timing
TOP       = tb_uart_top
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TB FAILED
PASS_MSG  = TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
